// File: rtl/main_bus_pkg.sv
`default_nettype none

package main_bus_pkg;

    // One bus master's request, word addressed
    typedef struct packed {
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [23:1] a;
        logic [15:0] dout;
    } bus_cycle_t;

    // Memory map view: A[23:20], A[19:16], A[15:1]
    typedef struct packed {
        logic [3:0]  top;
        logic [3:0]  mid;
        logic [14:0] low;
    } region_view_t;

    // I/O view: A[23:9], offset A[8:3], A[2:1]
    // Register index A[3:1] is {offset[0], sub}
    typedef struct packed {
        logic [14:0] high;
        logic [5:0]  offset;
        logic [1:0]  sub;
    } io_view_t;

    typedef union packed {
        region_view_t region;
        io_view_t     io;
    } bus_addr_u;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic oram;
        logic qs;
        logic io;
    } mem_sel_t;

    typedef struct packed {
        logic in0;
        logic in1;
        logic in2;
        logic vol;
        logic eeprom;
        logic out;
        logic obank;
        logic objcfg;
    } io_sel_t;

    // What a master sees when it does not own the bus
    parameter bus_cycle_t BUS_IDLE = '{
        as_n:  1'b1,
        uds_n: 1'b1,
        lds_n: 1'b1,
        rnw:   1'b1,
        a:     23'd0,
        dout:  16'd0
    };

endpackage

`default_nettype wire

// File: rtl/cabinet_pkg.sv
`default_nettype none

package cabinet_pkg;

    // Joystick wiring of the cabinet
    typedef enum logic [1:0] {
        JOY_SIX    = 2'b00,
        JOY_PUZZLE = 2'b01,
        JOY_PLAIN  = 2'b10
    } joymode_e;

    // Raw cabinet inputs, active low
    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [9:0] joy3;
        logic [9:0] joy4;
        logic [7:0] paddle1;
        logic [7:0] paddle2;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       test;
    } cab_in_t;

endpackage

`default_nettype wire

// File: rtl/bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter #(
    parameter bit DMA_FIRST = 1'b0
) (
    input  wire                     clk,
    input  wire                     rst,
    input  main_bus_pkg::bus_cycle_t cpu_bus,
    input  main_bus_pkg::bus_cycle_t dma_bus,
    input  wire                     busreq,
    output logic                    busack,
    output main_bus_pkg::bus_cycle_t grant_bus,
    output logic                    dma_owner
);

    // CPU cycle admitted and in progress
    logic cpu_act;
    logic dma_own_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_act   <= 1'b0;
            dma_own_q <= 1'b0;
        end else begin
            if (cpu_act) begin
                // CPU cycle ends when as_n goes back high
                if (cpu_bus.as_n) begin
                    cpu_act <= 1'b0;
                end
            end else if (dma_own_q) begin
                // Give the bus back once DMA is idle and busreq is gone
                if (!busreq && dma_bus.as_n) begin
                    dma_own_q <= 1'b0;
                end
            end else begin
                // Idle bus, tie resolved by DMA_FIRST
                if (busreq && (cpu_bus.as_n || DMA_FIRST)) begin
                    dma_own_q <= 1'b1;
                end else if (!cpu_bus.as_n) begin
                    cpu_act <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        if (cpu_act) begin
            grant_bus = cpu_bus;
        end else if (dma_own_q) begin
            grant_bus = dma_bus;
        end else begin
            grant_bus = main_bus_pkg::BUS_IDLE;
        end
    end

    assign dma_owner = dma_own_q;
    // The CPU sees the grant acknowledge for as long as DMA owns the bus
    assign busack    = dma_own_q;

endmodule

`default_nettype wire

// File: rtl/addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module addr_decoder (
    input  wire                     clk,
    input  wire                     rst,
    input  main_bus_pkg::bus_cycle_t grant_bus,
    input  wire [15:0]              oram_base,
    output main_bus_pkg::mem_sel_t  mem_sel,
    output main_bus_pkg::io_sel_t   io_sel,
    output logic [20:0]             rom_addr,
    output logic [22:0]             qs_addr
);

    // I/O offsets, A[8:3]
    localparam logic [5:0] OFS_IN0    = 6'h00;
    localparam logic [5:0] OFS_IN1    = 6'h02;
    localparam logic [5:0] OFS_IN2    = 6'h04;
    localparam logic [5:0] OFS_VOL    = 6'h06;
    localparam logic [5:0] OFS_EEPROM = 6'h08;
    localparam logic [5:0] OFS_OBANK  = 6'h1c;

    main_bus_pkg::bus_addr_u addr;
    logic                    io_hit;
    logic                    wr;
    logic [3:0]              top;
    logic [3:0]              mid;

    assign addr   = grant_bus.a;
    assign top    = addr.region.top;
    assign mid    = addr.region.mid;
    assign wr     = !grant_bus.rnw;
    // 80_0000 to 87_FFFF
    assign io_hit = top == 4'h8 && !mid[3];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_sel <= '0;
            io_sel  <= '0;
        end else if (!grant_bus.as_n) begin
            mem_sel.rom  <= top[3:2] == 2'b00;
            mem_sel.ram  <= &{top, mid};
            // 90_0000 to 92_FFFF
            mem_sel.vram <= top == 4'h9 && mid[3:2] == 2'b00 && mid[1:0] != 2'b11;
            mem_sel.oram <= top == 4'h7 && mid == oram_base[11:8];
            mem_sel.qs   <= top == 4'h6 && mid[3:1] == 3'd0;
            mem_sel.io   <= io_hit;

            io_sel.in0    <= io_hit && addr.io.offset == OFS_IN0;
            io_sel.in1    <= io_hit && addr.io.offset == OFS_IN1;
            io_sel.in2    <= io_hit && addr.io.offset == OFS_IN2;
            io_sel.vol    <= io_hit && addr.io.offset == OFS_VOL;
            // EEPROM pins and sound reset share one word, split by lane
            io_sel.eeprom <= io_hit && addr.io.offset == OFS_EEPROM && wr;
            io_sel.out    <= io_hit && addr.io.offset == OFS_EEPROM && wr;
            io_sel.obank  <= io_hit && addr.io.offset == OFS_OBANK && wr;
            io_sel.objcfg <= top == 4'h4 && wr;
        end else begin
            mem_sel <= '0;
            io_sel  <= '0;
        end
    end

    // Addresses follow the cycle, selects qualify them
    always_ff @(posedge clk) begin
        if (!grant_bus.as_n) begin
            rom_addr <= grant_bus.a[21:1];
            qs_addr  <= grant_bus.a;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sys_regs.sv
`timescale 1ns/100ps
`default_nettype none

module sys_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  main_bus_pkg::bus_cycle_t grant_bus,
    input  main_bus_pkg::io_sel_t   io_sel,
    input  cabinet_pkg::joymode_e   joymode,
    output logic                    eeprom_sclk,
    output logic                    eeprom_sdi,
    output logic                    eeprom_scs,
    output logic                    z80_rstn,
    output logic                    obank,
    output logic [15:0]             oram_base,
    output logic                    paddle_en
);

    main_bus_pkg::bus_addr_u addr;
    logic [2:0]              reg_idx;
    logic                    wr_hi;
    logic                    wr_lo;
    logic [15:0]             d;

    assign addr    = grant_bus.a;
    assign reg_idx = {addr.io.offset[0], addr.io.sub};
    assign d       = grant_bus.dout;

    // Byte lane write enables, only inside the cycle
    assign wr_hi = !grant_bus.as_n && !grant_bus.rnw && !grant_bus.uds_n;
    assign wr_lo = !grant_bus.as_n && !grant_bus.rnw && !grant_bus.lds_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_scs  <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_sdi  <= 1'b0;
            z80_rstn    <= 1'b0;
            obank       <= 1'b0;
            oram_base   <= 16'h0000;
            paddle_en   <= 1'b0;
        end else begin
            if (io_sel.eeprom && wr_hi) begin
                eeprom_sdi  <= d[12];
                eeprom_sclk <= d[13];
                eeprom_scs  <= d[14];
            end
            // Paddle switch only exists on puzzle cabinets
            if (io_sel.eeprom && wr_lo && joymode == cabinet_pkg::JOY_PUZZLE) begin
                paddle_en <= d[1];
            end
            if (io_sel.out && wr_lo) begin
                z80_rstn <= d[3];
            end
            if (io_sel.obank && wr_lo) begin
                obank <= d[0];
            end
            // Object RAM base lives at register 0 of the object block
            if (io_sel.objcfg && reg_idx == 3'd0) begin
                if (wr_hi) begin
                    oram_base[15:8] <= d[15:8];
                end
                if (wr_lo) begin
                    oram_base[7:0] <= d[7:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/input_ports.sv
`timescale 1ns/100ps
`default_nettype none

module input_ports (
    input  wire                    clk,
    input  cabinet_pkg::cab_in_t   cab_in,
    input  cabinet_pkg::joymode_e  joymode,
    input  wire                    paddle_en,
    input  wire                    eeprom_sdo,
    input  main_bus_pkg::io_sel_t  io_sel,
    output logic [15:0]            sys_data
);

    logic [15:0] in0;
    logic [15:0] in1;
    logic [15:0] in2;

    // Input words, sampled every clock
    always_ff @(posedge clk) begin
        if (paddle_en) begin
            in0 <= {cab_in.paddle2, cab_in.paddle1};
        end else begin
            in0 <= {cab_in.joy2[7:0], cab_in.joy1[7:0]};
        end
        in1 <= {cab_in.joy4[7:0], cab_in.joy3[7:0]};
        in2 <= {cab_in.coin, cab_in.start, 5'b11111,
                cab_in.service, cab_in.test, eeprom_sdo};

        if (joymode == cabinet_pkg::JOY_SIX) begin
            // Only two players, extra buttons go to in1
            in0[15]  <= 1'b1;
            in0[7]   <= 1'b1;
            in1      <= 16'hffff;
            in1[2:0] <= cab_in.joy1[9:7];
            in1[5:4] <= cab_in.joy2[8:7];
            in2[14]  <= cab_in.joy2[9];
        end
    end

    always_ff @(posedge clk) begin
        if (io_sel.in0) begin
            sys_data <= in0;
        end else if (io_sel.in1) begin
            sys_data <= in1;
        end else if (io_sel.in2) begin
            sys_data <= in2;
        end else begin
            sys_data <= 16'hffff;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dtack_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dtack_gen (
    input  wire                     clk,
    input  wire                     rst,
    input  main_bus_pkg::bus_cycle_t grant_bus,
    input  wire                     dma_owner,
    input  main_bus_pkg::mem_sel_t  mem_sel,
    input  wire                     rom_ok,
    input  wire                     ram_ok,
    input  wire                     qs_waitn,
    output logic                    cpu_dtack_n,
    output logic                    dma_dtack_n
);

    main_bus_pkg::bus_addr_u addr;
    logic                    cyc_act;
    logic                    waited;
    logic                    ack;
    logic                    bus_cs;
    logic                    busy;
    logic                    one_wait;

    assign addr   = grant_bus.a;
    assign bus_cs = |{mem_sel.rom, mem_sel.ram, mem_sel.vram, mem_sel.oram, mem_sel.qs};
    assign busy   = (mem_sel.rom & ~rom_ok)
                  | ((mem_sel.ram | mem_sel.vram | mem_sel.oram) & ~ram_ok)
                  | (mem_sel.qs & ~qs_waitn);
    // Below 5MB and from 8MB up
    assign one_wait = addr.region.top < 4'h5 || addr.region.top >= 4'h8;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_act <= 1'b0;
            waited  <= 1'b0;
            ack     <= 1'b0;
        end else if (grant_bus.as_n) begin
            cyc_act <= 1'b0;
            waited  <= 1'b0;
            ack     <= 1'b0;
        end else begin
            // Aligned with the decoder's registered selects
            cyc_act <= 1'b1;
            if (cyc_act && !ack) begin
                if (bus_cs) begin
                    ack <= !busy;
                end else if (one_wait && !waited) begin
                    waited <= 1'b1;
                end else begin
                    ack <= 1'b1;
                end
            end
        end
    end

    // Ownership only changes between cycles
    assign cpu_dtack_n = !(ack && !dma_owner);
    assign dma_dtack_n = !(ack && dma_owner);

endmodule

`default_nettype wire

// File: rtl/main_bus_top.sv
`timescale 1ns/100ps
`default_nettype none

module main_bus_top #(
    parameter bit DMA_FIRST = 1'b0
) (
    input  wire                      clk,
    input  wire                      rst,
    // Bus masters
    input  main_bus_pkg::bus_cycle_t cpu_bus,
    input  main_bus_pkg::bus_cycle_t dma_bus,
    input  wire                      busreq,
    output logic                     busack,
    output logic                     cpu_dtack_n,
    output logic                     dma_dtack_n,
    output logic [15:0]              cpu_din,
    output logic [15:0]              dma_din,
    // Memory side
    output main_bus_pkg::mem_sel_t   mem_sel,
    output logic [20:0]              rom_addr,
    input  wire  [15:0]              rom_data,
    input  wire                      rom_ok,
    output logic [16:0]              ram_addr,
    output logic [15:0]              ram_dout,
    output logic                     uds_wn,
    output logic                     lds_wn,
    input  wire  [15:0]              ram_data,
    input  wire                      ram_ok,
    // Second video chip
    output logic                     ppu2_cs,
    input  wire  [15:0]              mmr_dout,
    // Sound CPU
    output logic [22:0]              qs_addr,
    input  wire  [7:0]               qs_din,
    input  wire                      qs_waitn,
    input  wire  [12:0]              volume,
    output logic                     z80_rstn,
    // Cabinet and system registers
    input  cabinet_pkg::cab_in_t     cab_in,
    input  cabinet_pkg::joymode_e    joymode,
    input  wire                      eeprom_sdo,
    output logic                     eeprom_sclk,
    output logic                     eeprom_sdi,
    output logic                     eeprom_scs,
    output logic                     obank,
    output logic [15:0]              oram_base
);

    main_bus_pkg::bus_cycle_t grant_bus;
    main_bus_pkg::io_sel_t    io_sel;
    main_bus_pkg::bus_addr_u  addr;
    logic                     dma_owner;
    logic                     paddle_en;
    logic [15:0]              sys_data;
    logic [15:0]              rd_mux;

    bus_arbiter #(.DMA_FIRST(DMA_FIRST)) u_arbiter (
        .clk(clk), .rst(rst), .cpu_bus(cpu_bus), .dma_bus(dma_bus),
        .busreq(busreq), .busack(busack), .grant_bus(grant_bus), .dma_owner(dma_owner)
    );

    addr_decoder u_decoder (
        .clk(clk), .rst(rst), .grant_bus(grant_bus), .oram_base(oram_base),
        .mem_sel(mem_sel), .io_sel(io_sel), .rom_addr(rom_addr), .qs_addr(qs_addr)
    );

    sys_regs u_sys_regs (
        .clk(clk), .rst(rst), .grant_bus(grant_bus), .io_sel(io_sel), .joymode(joymode),
        .eeprom_sclk(eeprom_sclk), .eeprom_sdi(eeprom_sdi), .eeprom_scs(eeprom_scs),
        .z80_rstn(z80_rstn), .obank(obank), .oram_base(oram_base), .paddle_en(paddle_en)
    );

    input_ports u_inputs (
        .clk(clk), .cab_in(cab_in), .joymode(joymode), .paddle_en(paddle_en),
        .eeprom_sdo(eeprom_sdo), .io_sel(io_sel), .sys_data(sys_data)
    );

    dtack_gen u_dtack (
        .clk(clk), .rst(rst), .grant_bus(grant_bus), .dma_owner(dma_owner),
        .mem_sel(mem_sel), .rom_ok(rom_ok), .ram_ok(ram_ok), .qs_waitn(qs_waitn),
        .cpu_dtack_n(cpu_dtack_n), .dma_dtack_n(dma_dtack_n)
    );

    assign addr     = grant_bus.a;
    // I/O offset 101_xxx
    assign ppu2_cs  = mem_sel.io && addr.io.offset[5:3] == 3'b101;
    // RAM and VRAM share the SDRAM, keep them apart
    assign ram_addr = mem_sel.ram ? {2'b00, addr.region.low} : grant_bus.a[17:1];
    assign ram_dout = grant_bus.dout;
    assign uds_wn   = grant_bus.rnw | grant_bus.uds_n;
    assign lds_wn   = grant_bus.rnw | grant_bus.lds_n;

    always_comb begin
        if (io_sel.in0 | io_sel.in1 | io_sel.in2) begin
            rd_mux = sys_data;
        end else if (mem_sel.ram | mem_sel.vram | mem_sel.oram) begin
            rd_mux = ram_data;
        end else if (mem_sel.rom) begin
            rd_mux = rom_data;
        end else if (ppu2_cs) begin
            rd_mux = mmr_dout;
        end else if (io_sel.vol) begin
            rd_mux = {3'b111, volume};
        end else if (mem_sel.qs) begin
            rd_mux = {8'hff, qs_din};
        end else begin
            rd_mux = 16'hffff;
        end
    end

    // Each master keeps its last read word
    always_ff @(posedge clk) begin
        if (dma_owner) begin
            dma_din <= rd_mux;
        end else begin
            cpu_din <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_main_bus.sv
`timescale 1ns/100ps
`default_nettype none

module tb_main_bus;

    localparam int CYC_TIMEOUT    = 40;
    localparam int NUM_BUS_CYCLES = 31;
    // Each bus cycle may use its whole timeout, plus reset and idle gaps
    localparam int RUN_LIMIT      = NUM_BUS_CYCLES * (CYC_TIMEOUT + 2) + 100;

    // Select patterns in mem_sel_t order: rom ram vram oram qs io
    localparam logic [5:0] SEL_NONE = 6'b000000;
    localparam logic [5:0] SEL_ROM  = 6'b100000;
    localparam logic [5:0] SEL_RAM  = 6'b010000;
    localparam logic [5:0] SEL_VRAM = 6'b001000;
    localparam logic [5:0] SEL_ORAM = 6'b000100;

    // Byte addresses, I/O offset sits in A[8:3]
    localparam logic [23:0] IO_IN0      = 24'h800000;
    localparam logic [23:0] IO_IN1      = 24'h800010;
    localparam logic [23:0] IO_IN2      = 24'h800020;
    localparam logic [23:0] IO_VOL      = 24'h800030;
    localparam logic [23:0] IO_EEPROM   = 24'h800040;
    localparam logic [23:0] IO_UNMAPPED = 24'h800080;
    localparam logic [23:0] IO_OBANK    = 24'h8000e0;
    localparam logic [23:0] IO_PPU2     = 24'h800140;
    localparam logic [23:0] QS_WORD     = 24'h600100;
    localparam logic [23:0] OBJCFG      = 24'h400000;

    // Strobes as {uds_n, lds_n}
    localparam logic [1:0] LANE_BOTH = 2'b00;
    localparam logic [1:0] LANE_HI   = 2'b01;
    localparam logic [1:0] LANE_LO   = 2'b10;

    logic                     clk;
    logic                     rst;
    main_bus_pkg::bus_cycle_t cpu_bus;
    main_bus_pkg::bus_cycle_t dma_bus;
    logic                     busreq;
    logic                     busack;
    logic                     cpu_dtack_n;
    logic                     dma_dtack_n;
    logic [15:0]              cpu_din;
    logic [15:0]              dma_din;
    main_bus_pkg::mem_sel_t   mem_sel;
    logic [20:0]              rom_addr;
    logic [15:0]              rom_data;
    logic                     rom_ok;
    logic [16:0]              ram_addr;
    logic [15:0]              ram_dout;
    logic                     uds_wn;
    logic                     lds_wn;
    logic [15:0]              ram_data;
    logic                     ram_ok;
    logic                     ppu2_cs;
    logic [15:0]              mmr_dout;
    logic [22:0]              qs_addr;
    logic [7:0]               qs_din;
    logic                     qs_waitn;
    logic [12:0]              volume;
    logic                     z80_rstn;
    cabinet_pkg::cab_in_t     cab_in;
    cabinet_pkg::joymode_e    joymode;
    logic                     eeprom_sdo;
    logic                     eeprom_sclk;
    logic                     eeprom_sdi;
    logic                     eeprom_scs;
    logic                     obank;
    logic [15:0]              oram_base;

    logic [31:0]              rng;
    int                       errors;
    int                       bus_cycles;
    int                       cycle_count;
    logic                     paddle_model;
    logic                     mem_open;
    int                       mem_delay;

    // Snapshot taken when a cycle gets its dtack
    main_bus_pkg::mem_sel_t   last_sel;
    logic [20:0]              last_rom_addr;
    logic [15:0]              last_rom_data;
    logic [15:0]              last_ram_data;

    main_bus_top #(.DMA_FIRST(1'b0)) dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= RUN_LIMIT) begin
            $display("Run stopped after %0d clock cycles without finishing", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    // Memory side: random latency and random data per access
    always @(negedge clk) begin : mem_model
        logic [31:0] rnd;
        if (rst) begin
            mem_open = 1'b0;
            rom_ok   = 1'b0;
            ram_ok   = 1'b0;
        end else if (mem_sel.rom | mem_sel.ram | mem_sel.vram | mem_sel.oram) begin
            if (!mem_open) begin
                mem_open  = 1'b1;
                rnd       = next_rand();
                mem_delay = int'(rnd % 32'd5);
                rnd       = next_rand();
                rom_data  = rnd[15:0];
                ram_data  = rnd[31:16];
            end else if (mem_delay > 0) begin
                mem_delay--;
            end
            if (mem_delay == 0) begin
                rom_ok = mem_sel.rom;
                ram_ok = !mem_sel.rom;
            end
        end else begin
            mem_open = 1'b0;
            rom_ok   = 1'b0;
            ram_ok   = 1'b0;
        end
    end

    rom_wait_check: assert property (@(posedge clk) disable iff (rst)
        ($fell(cpu_dtack_n) && mem_sel.rom) |-> $past(rom_ok))
        else report_fail("dtack fell before rom_ok");

    busack_block_check: assert property (@(posedge clk) disable iff (rst)
        busack |-> cpu_dtack_n)
        else report_fail("CPU got dtack while busack was high");

    busack_rise_check: assert property (@(posedge clk) disable iff (rst)
        $rose(busack) |-> $past(cpu_bus.as_n))
        else report_fail("busack rose during a CPU cycle");

    select_onehot_check: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mem_sel))
        else report_fail("more than one memory select active");

    // Expected input words from the cabinet formatting rules
    function automatic logic [15:0] expect_input(input int idx);
        logic [15:0] w;
        logic        six;
        six = joymode == cabinet_pkg::JOY_SIX;
        case (idx)
            0: begin
                if (paddle_model) begin
                    w = {cab_in.paddle2, cab_in.paddle1};
                end else begin
                    w = {cab_in.joy2[7:0], cab_in.joy1[7:0]};
                end
                if (six) begin
                    w[15] = 1'b1;
                    w[7]  = 1'b1;
                end
            end
            1: begin
                if (six) begin
                    w      = 16'hffff;
                    w[2:0] = cab_in.joy1[9:7];
                    w[5:4] = cab_in.joy2[8:7];
                end else begin
                    w = {cab_in.joy4[7:0], cab_in.joy3[7:0]};
                end
            end
            default: begin
                w = {cab_in.coin, cab_in.start, 5'b11111,
                     cab_in.service, cab_in.test, eeprom_sdo};
                if (six) begin
                    w[14] = cab_in.joy2[9];
                end
            end
        endcase
        return w;
    endfunction

    // Memory-side outputs while the acknowledged cycle is still on the bus
    task automatic check_bus_outputs(
        input logic [23:0] baddr,
        input bit          rnw,
        input logic [1:0]  lanes_n,
        input logic [15:0] wdata
    );
        logic ppu2_exp;
        // Second video chip sits at I/O offsets 101_xxx
        ppu2_exp = baddr[23:19] == 5'b10000 && baddr[8:6] == 3'b101;
        assert (uds_wn == (rnw || lanes_n[1]) && lds_wn == (rnw || lanes_n[0]))
            else report_fail($sformatf("write strobes %b%b at %h", uds_wn, lds_wn, baddr));
        assert (qs_addr == baddr[23:1])
            else report_fail($sformatf("qs_addr %h for cycle at %h", qs_addr, baddr));
        assert (ppu2_cs == ppu2_exp)
            else report_fail($sformatf("ppu2_cs %b at %h", ppu2_cs, baddr));
        if (!rnw) begin
            assert (ram_dout == wdata)
                else report_fail($sformatf("ram_dout %h, expected %h", ram_dout, wdata));
        end
        if (baddr[23:16] == 8'hff) begin
            assert (ram_addr == {2'b00, baddr[15:1]})
                else report_fail($sformatf("ram_addr %h at %h", ram_addr, baddr));
        end
    endtask

    task automatic run_cycle(
        input  bit          use_dma,
        input  logic [23:0] baddr,
        input  bit          rnw,
        input  logic [1:0]  lanes_n,
        input  logic [15:0] wdata,
        output logic [15:0] rdata
    );
        main_bus_pkg::bus_cycle_t cyc;
        int                       waits;
        bit                       acked;
        cyc       = main_bus_pkg::BUS_IDLE;
        cyc.as_n  = 1'b0;
        cyc.uds_n = lanes_n[1];
        cyc.lds_n = lanes_n[0];
        cyc.rnw   = rnw;
        cyc.a     = baddr[23:1];
        cyc.dout  = wdata;
        waits     = 0;
        acked     = 1'b0;
        @(negedge clk);
        if (use_dma) begin
            dma_bus = cyc;
        end else begin
            cpu_bus = cyc;
        end
        while (!acked && waits < CYC_TIMEOUT) begin
            @(negedge clk);
            waits++;
            acked = use_dma ? !dma_dtack_n : !cpu_dtack_n;
        end
        if (!acked) begin
            errors++;
            $display("Bus cycle to %h got no dtack within %0d cycles", baddr, CYC_TIMEOUT);
        end else begin
            check_bus_outputs(baddr, rnw, lanes_n, wdata);
        end
        rdata         = use_dma ? dma_din : cpu_din;
        last_sel      = mem_sel;
        last_rom_addr = rom_addr;
        last_rom_data = rom_data;
        last_ram_data = ram_data;
        if (use_dma) begin
            dma_bus = main_bus_pkg::BUS_IDLE;
        end else begin
            cpu_bus = main_bus_pkg::BUS_IDLE;
        end
        bus_cycles++;
        @(negedge clk);
    endtask

    task automatic cpu_write(input logic [23:0] baddr, input logic [1:0] lanes_n,
                             input logic [15:0] data);
        logic [15:0] unused_rd;
        run_cycle(1'b0, baddr, 1'b0, lanes_n, data, unused_rd);
    endtask

    task automatic check_read(input logic [23:0] baddr, input logic [15:0] exp,
                              input string what);
        logic [15:0] rd;
        run_cycle(1'b0, baddr, 1'b1, LANE_BOTH, 16'h0000, rd);
        assert (rd == exp) else report_fail($sformatf("%s read %h, expected %h", what, rd, exp));
    endtask

    task automatic randomize_cabinet();
        logic [95:0] bits;
        bits       = {next_rand(), next_rand(), next_rand()};
        cab_in     = bits[$bits(cabinet_pkg::cab_in_t)-1:0];
        eeprom_sdo = bits[90];
    endtask

    initial begin : stimulus
        logic [31:0]           rnd;
        logic [23:0]           baddr;
        logic [15:0]           rd;
        logic [15:0]           rd_dma;
        cabinet_pkg::joymode_e mode_list [3];
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_bus      = main_bus_pkg::BUS_IDLE;
        dma_bus      = main_bus_pkg::BUS_IDLE;
        busreq       = 1'b0;
        rom_data     = 16'h0000;
        rom_ok       = 1'b0;
        ram_data     = 16'h0000;
        ram_ok       = 1'b0;
        mmr_dout     = 16'h1357;
        qs_din       = 8'h5a;
        qs_waitn     = 1'b1;
        volume       = 13'h0abc;
        cab_in       = '1;
        joymode      = cabinet_pkg::JOY_PLAIN;
        eeprom_sdo   = 1'b1;
        rng          = 32'h81c6;
        errors       = 0;
        bus_cycles   = 0;
        cycle_count  = 0;
        paddle_model = 1'b0;
        mem_open     = 1'b0;
        mem_delay    = 0;
        mode_list[0] = cabinet_pkg::JOY_SIX;
        mode_list[1] = cabinet_pkg::JOY_PLAIN;
        mode_list[2] = cabinet_pkg::JOY_PUZZLE;

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!busack && cpu_dtack_n && dma_dtack_n && mem_sel == SEL_NONE
                && !eeprom_scs && !eeprom_sclk && !eeprom_sdi && !z80_rstn
                && !obank && oram_base == 16'h0000)
            else report_fail("outputs not idle after reset");

        // ROM reads at random even addresses
        repeat (4) begin
            rnd   = next_rand();
            baddr = rnd[23:0] & 24'h3ffffe;
            run_cycle(1'b0, baddr, 1'b1, LANE_BOTH, 16'h0000, rd);
            assert (last_sel == SEL_ROM && last_rom_addr == baddr[21:1])
                else report_fail($sformatf("ROM select or address wrong at %h", baddr));
            assert (rd == last_rom_data)
                else report_fail($sformatf("ROM read %h, expected %h", rd, last_rom_data));
        end

        // Object RAM base, then matching and mismatching banks
        cpu_write(OBJCFG, LANE_BOTH, 16'h0a00);
        assert (oram_base == 16'h0a00) else report_fail("oram_base not written");
        run_cycle(1'b0, 24'h7a0000, 1'b1, LANE_BOTH, 16'h0000, rd);
        assert (last_sel == SEL_ORAM && rd == last_ram_data)
            else report_fail("ORAM read with matching bank wrong");
        run_cycle(1'b0, 24'h7b0000, 1'b1, LANE_BOTH, 16'h0000, rd);
        assert (last_sel == SEL_NONE && rd == 16'hffff)
            else report_fail("ORAM read with other bank was selected");
        run_cycle(1'b0, 24'hff1234, 1'b1, LANE_BOTH, 16'h0000, rd);
        assert (last_sel == SEL_RAM && rd == last_ram_data) else report_fail("RAM read wrong");
        run_cycle(1'b0, 24'h910000, 1'b1, LANE_BOTH, 16'h0000, rd);
        assert (last_sel == SEL_VRAM && rd == last_ram_data) else report_fail("VRAM read wrong");

        // System registers and byte lanes
        cpu_write(IO_EEPROM, LANE_HI, 16'h5008);
        assert (eeprom_scs && !eeprom_sclk && eeprom_sdi && !z80_rstn)
            else report_fail("upper lane EEPROM write wrong");
        cpu_write(IO_EEPROM, LANE_LO, 16'h0008);
        assert (z80_rstn && eeprom_scs && !eeprom_sclk && eeprom_sdi)
            else report_fail("lower lane write to the output register wrong");
        cpu_write(IO_OBANK, LANE_LO, 16'h0001);
        assert (obank) else report_fail("obank not set");
        cpu_write(IO_OBANK, LANE_HI, 16'h0000);
        assert (obank) else report_fail("upper lane write changed obank");

        // Input words per joystick mode
        for (int m = 0; m < 3; m++) begin
            @(negedge clk);
            joymode = mode_list[m];
            randomize_cabinet();
            check_read(IO_IN0, expect_input(0), $sformatf("in0 mode %0d", m));
            check_read(IO_IN1, expect_input(1), $sformatf("in1 mode %0d", m));
            check_read(IO_IN2, expect_input(2), $sformatf("in2 mode %0d", m));
        end
        cpu_write(IO_EEPROM, LANE_LO, 16'h000a);
        paddle_model = 1'b1;
        randomize_cabinet();
        check_read(IO_IN0, expect_input(0), "in0 with paddles");
        check_read(IO_UNMAPPED, 16'hffff, "unmapped I/O");
        check_read(IO_VOL, {3'b111, volume}, "volume");
        check_read(IO_PPU2, mmr_dout, "second video chip");
        check_read(QS_WORD, {8'hff, qs_din}, "sound RAM");

        // DMA request raised inside a CPU cycle
        fork
            run_cycle(1'b0, 24'h001000, 1'b1, LANE_BOTH, 16'h0000, rd);
            begin
                repeat (2) @(negedge clk);
                busreq = 1'b1;
            end
        join
        assert (!busack) else report_fail("busack high right after the CPU cycle");
        for (int i = 0; i < 16 && !busack; i++) begin
            @(negedge clk);
        end
        assert (busack) else report_fail("busack never rose");

        fork
            run_cycle(1'b0, 24'hff0100, 1'b1, LANE_BOTH, 16'h0000, rd);
            begin
                run_cycle(1'b1, 24'hff0200, 1'b1, LANE_BOTH, 16'h0000, rd_dma);
                assert (rd_dma == last_ram_data) else report_fail("DMA RAM read wrong");
                repeat (3) @(negedge clk);
                busreq = 1'b0;
                @(negedge clk);
                assert (!busack) else report_fail("busack still high after busreq fell");
            end
        join
        assert (rd == last_ram_data) else report_fail("held CPU RAM read wrong");

        $display("Bus cycles: %0d, errors: %0d", bus_cycles, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/main_bus_pkg.sv
rtl/cabinet_pkg.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/sys_regs.sv
rtl/input_ports.sv
rtl/dtack_gen.sv
rtl/main_bus_top.sv
verif/tb_main_bus.sv
